// ==== design/wiscFrontEnd_cfg.svh ====
`ifndef WISC_FRONT_END_CFG_SVH
`define WISC_FRONT_END_CFG_SVH

// Instruction memory address width, 64 words
`define IMEM_AW 6

// Entries in the instruction queue
`define QUEUE_DEPTH 4

`endif

// ==== design/wiscPkg.sv ====
`default_nettype none

`include "wiscFrontEnd_cfg.svh"

package wiscPkg;

  typedef logic [15:0] instrT;           // One instruction word
  typedef logic [`IMEM_AW-1:0] pcT;      // Word address into instruction memory
  typedef logic [4:0] opcodeT;           // Instruction bits 15 to 11, also the ALU opcode
  typedef logic [2:0] regIdxT;           // Register index, r0 to r7
  typedef logic [15:0] immT;             // Extended immediate

  // Fetch FSM
  typedef enum logic
  {
    FETCH_IDLE,
    FETCH_RUN
  } fetchStateT;

endpackage

`default_nettype wire

// ==== design/instrQueueIf.sv ====
`timescale 1ns/1ns
`default_nettype none

interface instrQueueIf import wiscPkg::*; ();

  logic  push;     // One strobe per word
  instrT word;
  pcT    addr;     // Address the word was fetched from
  logic  full;
  logic  pop;      // Head is consumed on this edge
  logic  empty;
  instrT rdWord;   // Head entry
  pcT    rdAddr;

  modport writer (output push, word, addr, input full);

  modport reader (output pop, input empty, rdWord, rdAddr);

  // Queue side, owns the levels and the head entry
  modport storage (input push, word, addr, pop, output full, empty, rdWord, rdAddr);

endinterface

`default_nettype wire

// ==== design/fetchUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wiscFrontEnd_cfg.svh"

module fetchUnit import wiscPkg::*; (
  input wire        clk,
  input wire        rstN,
  input wire        start,
  input wire        imemWe,
  input wire pcT    imemAddr,
  input wire instrT imemData,
  input wire        halted,
  instrQueueIf.writer q,
  output logic      busy
);

  localparam int ImemWords = 1 << `IMEM_AW;

  instrT      imem [ImemWords];
  pcT         pc;
  fetchStateT state;
  logic       doPush;

  // Load port from the testbench
  always_ff @(posedge clk)
  begin
    if (imemWe)
      imem[imemAddr] <= imemData;
  end

  // Push one word per cycle until full, halted or restarted
  assign doPush = (state == FETCH_RUN) && !q.full && !halted && !start;

  assign q.push = doPush;
  assign q.word = imem[pc];   // Asynchronous read at the PC
  assign q.addr = pc;

  assign busy = (state == FETCH_RUN);

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= FETCH_IDLE;
      pc    <= '0;
    end
    else if (start)
    begin
      state <= FETCH_RUN;
      pc    <= '0;
    end
    else if (state == FETCH_RUN)
    begin
      if (halted)
        state <= FETCH_IDLE;
      else if (doPush)
      begin
        pc <= pc + 1'b1;
        if (pc == '1)
          state <= FETCH_IDLE;   // Last address pushed
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/instrQueue.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wiscFrontEnd_cfg.svh"

module instrQueue import wiscPkg::*; (
  input wire clk,
  input wire rstN,
  input wire flush,
  instrQueueIf.storage q
);

  localparam int Depth = `QUEUE_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;

  instrT            wordMem [Depth];
  pcT               addrMem [Depth];
  logic [PtrW-1:0]  rdPtr;
  logic [PtrW-1:0]  wrPtr;
  logic [PtrW:0]    count;   // Occupancy, 0 to Depth

  assign q.full   = (count == (PtrW+1)'(Depth));
  assign q.empty  = (count == '0);
  assign q.rdWord = wordMem[rdPtr];   // Head visible without a pop
  assign q.rdAddr = addrMem[rdPtr];

  // Entry storage
  always_ff @(posedge clk)
  begin
    if (q.push)
    begin
      wordMem[wrPtr] <= q.word;
      addrMem[wrPtr] <= q.addr;
    end
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else if (flush)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (q.push)
        wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      if (q.pop)
        rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      case ({q.push, q.pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/controlDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlDecoder import wiscPkg::*; (
  input wire opcodeT opcode,
  output logic       regDst,      // Write register from rd field
  output logic       jump,
  output logic       branch,
  output logic       memRead,
  output logic       memToReg,    // Write back from data memory
  output logic       memWrite,
  output logic       aluSrc,      // Immediate as second ALU operand
  output logic       regWrite,
  output logic       fiveBitImm,  // Immediate from bits 4 to 0
  output logic       zeroExtend,
  output logic       halt
);

  always_comb
  begin
    regDst     = 1'b0;
    jump       = 1'b0;
    branch     = 1'b0;
    memRead    = 1'b0;
    memToReg   = 1'b0;
    memWrite   = 1'b0;
    aluSrc     = 1'b0;
    regWrite   = 1'b0;
    fiveBitImm = 1'b0;
    zeroExtend = 1'b0;
    halt       = 1'b0;

    case (opcode)
      5'b0_0000:                           // HALT
        halt = 1'b1;
      5'b0_0001, 5'b0_0010, 5'b0_0011:     // NOP, siic, RTI
      begin
      end
      5'b0_0100:                           // J
        jump = 1'b1;
      5'b0_0101:                           // JR
      begin
        jump   = 1'b1;
        aluSrc = 1'b1;
      end
      5'b0_0110:                           // JAL
      begin
        jump     = 1'b1;
        regWrite = 1'b1;
      end
      5'b0_0111:                           // JALR
      begin
        jump     = 1'b1;
        regWrite = 1'b1;
        aluSrc   = 1'b1;
      end
      5'b0_1000, 5'b0_1001:                // ADDI, SUBI
      begin
        fiveBitImm = 1'b1;
        aluSrc     = 1'b1;
        regWrite   = 1'b1;
      end
      5'b0_1010, 5'b0_1011:                // XORI, ANDNI
      begin
        fiveBitImm = 1'b1;
        aluSrc     = 1'b1;
        regWrite   = 1'b1;
        zeroExtend = 1'b1;
      end
      5'b0_1100, 5'b0_1101, 5'b0_1110, 5'b0_1111:   // BEQZ, BNEZ, BLTZ, BGEZ
      begin
        aluSrc = 1'b1;
        branch = 1'b1;
      end
      5'b1_0000:                           // ST
      begin
        aluSrc     = 1'b1;
        fiveBitImm = 1'b1;
        memWrite   = 1'b1;
        memRead    = 1'b1;
        memToReg   = 1'b1;
      end
      5'b1_0001:                           // LD
      begin
        memRead    = 1'b1;
        memToReg   = 1'b1;
        fiveBitImm = 1'b1;
        aluSrc     = 1'b1;
        regWrite   = 1'b1;
      end
      5'b1_0010:                           // SLBI
      begin
        regWrite   = 1'b1;
        aluSrc     = 1'b1;
        zeroExtend = 1'b1;
      end
      5'b1_0011:                           // STU writes back the address
      begin
        regWrite   = 1'b1;
        fiveBitImm = 1'b1;
        memWrite   = 1'b1;
        memRead    = 1'b1;
        aluSrc     = 1'b1;
      end
      5'b1_0100, 5'b1_0101, 5'b1_0111:     // ROLI, SLLI, SRLI
      begin
        fiveBitImm = 1'b1;
        aluSrc     = 1'b1;
        regWrite   = 1'b1;
      end
      5'b1_0110:                           // RORI without aluSrc
      begin
        fiveBitImm = 1'b1;
        regWrite   = 1'b1;
      end
      5'b1_1000:                           // LBI
      begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
      end
      5'b1_1001, 5'b1_1010, 5'b1_1011,     // BTR, shift group, arith group
      5'b1_1100, 5'b1_1101, 5'b1_1110, 5'b1_1111:   // SEQ, SLT, SLE, SCO
      begin
        regDst   = 1'b1;
        regWrite = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/decodeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeStage import wiscPkg::*; (
  input wire   clk,
  input wire   rstN,
  input wire   start,
  input wire   stall,
  instrQueueIf.reader q,
  output logic halted,
  output logic decValid,
  output pcT   decAddr,
  output opcodeT aluOp,
  output logic regDst,
  output logic jump,
  output logic branch,
  output logic memRead,
  output logic memToReg,
  output logic memWrite,
  output logic aluSrc,
  output logic regWrite,
  output logic fiveBitImm,
  output logic zeroExtend,
  output logic halt,
  output regIdxT rsIdx,
  output regIdxT rtIdx,
  output regIdxT wrIdx,
  output immT  imm
);

  instrT  w;
  opcodeT opcode;
  logic   pop;
  logic   cRegDst, cJump, cBranch, cMemRead, cMemToReg, cMemWrite;
  logic   cAluSrc, cRegWrite, cFiveBitImm, cZeroExtend, cHalt;
  immT    immNxt;

  assign w      = q.rdWord;
  assign opcode = w[15:11];

  // No pop on start, the queue is being flushed
  assign pop   = !q.empty && !stall && !halted && !start;
  assign q.pop = pop;

  controlDecoder i_ctrl (
    .opcode     (opcode),
    .regDst     (cRegDst),
    .jump       (cJump),
    .branch     (cBranch),
    .memRead    (cMemRead),
    .memToReg   (cMemToReg),
    .memWrite   (cMemWrite),
    .aluSrc     (cAluSrc),
    .regWrite   (cRegWrite),
    .fiveBitImm (cFiveBitImm),
    .zeroExtend (cZeroExtend),
    .halt       (cHalt)
  );

  always_comb
  begin
    if (cFiveBitImm)
      immNxt = cZeroExtend ? {11'b0, w[4:0]} : {{11{w[4]}}, w[4:0]};
    else
      immNxt = cZeroExtend ? {8'b0, w[7:0]} : {{8{w[7]}}, w[7:0]};
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      decValid <= 1'b0;
      halted   <= 1'b0;
    end
    else
    begin
      decValid <= pop;
      if (start)
        halted <= 1'b0;
      else if (pop && cHalt)
        halted <= 1'b1;   // Set together with the halt bundle
    end
  end

  // Decoded bundle, held until the next pop
  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      decAddr    <= q.rdAddr;
      aluOp      <= opcode;
      regDst     <= cRegDst;
      jump       <= cJump;
      branch     <= cBranch;
      memRead    <= cMemRead;
      memToReg   <= cMemToReg;
      memWrite   <= cMemWrite;
      aluSrc     <= cAluSrc;
      regWrite   <= cRegWrite;
      fiveBitImm <= cFiveBitImm;
      zeroExtend <= cZeroExtend;
      halt       <= cHalt;
      rsIdx      <= w[10:8];
      rtIdx      <= w[7:5];
      wrIdx      <= cRegDst ? w[4:2] : w[10:8];
      imm        <= immNxt;
    end
  end

endmodule

`default_nettype wire

// ==== design/wiscFrontEnd.sv ====
`timescale 1ns/1ns
`default_nettype none

module wiscFrontEnd import wiscPkg::*; (
  input wire        clk,
  input wire        rstN,
  input wire        start,
  input wire        stall,
  input wire        imemWe,
  input wire pcT    imemAddr,
  input wire instrT imemData,
  output logic      busy,
  output logic      halt,        // Decode halted level
  output logic      decValid,
  output pcT        decAddr,
  output opcodeT    aluOp,
  output logic      regDst,
  output logic      jump,
  output logic      branch,
  output logic      memRead,
  output logic      memToReg,
  output logic      memWrite,
  output logic      aluSrc,
  output logic      regWrite,
  output logic      fiveBitImm,
  output logic      zeroExtend,
  output regIdxT    rsIdx,
  output regIdxT    rtIdx,
  output regIdxT    wrIdx,
  output immT       imm
);

  logic halted;

  instrQueueIf fetchBus ();    // Fetch side view
  instrQueueIf decodeBus ();   // Queue and decode side

  // Fetch writes reach the queue, queue levels reach fetch
  assign decodeBus.push  = fetchBus.push;
  assign decodeBus.word  = fetchBus.word;
  assign decodeBus.addr  = fetchBus.addr;
  assign fetchBus.full   = decodeBus.full;
  assign fetchBus.empty  = decodeBus.empty;
  assign fetchBus.pop    = decodeBus.pop;
  assign fetchBus.rdWord = decodeBus.rdWord;
  assign fetchBus.rdAddr = decodeBus.rdAddr;

  assign halt = halted;

  fetchUnit i_fetch (
    .clk      (clk),
    .rstN     (rstN),
    .start    (start),
    .imemWe   (imemWe),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .halted   (halted),
    .q        (fetchBus.writer),
    .busy     (busy)
  );

  instrQueue i_queue (
    .clk   (clk),
    .rstN  (rstN),
    .flush (start),
    .q     (decodeBus.storage)
  );

  decodeStage i_decode (
    .clk        (clk),
    .rstN       (rstN),
    .start      (start),
    .stall      (stall),
    .q          (decodeBus.reader),
    .halted     (halted),
    .decValid   (decValid),
    .decAddr    (decAddr),
    .aluOp      (aluOp),
    .regDst     (regDst),
    .jump       (jump),
    .branch     (branch),
    .memRead    (memRead),
    .memToReg   (memToReg),
    .memWrite   (memWrite),
    .aluSrc     (aluSrc),
    .regWrite   (regWrite),
    .fiveBitImm (fiveBitImm),
    .zeroExtend (zeroExtend),
    .halt       (),            // Same as halted at each decValid
    .rsIdx      (rsIdx),
    .rtIdx      (rtIdx),
    .wrIdx      (wrIdx),
    .imm        (imm)
  );

endmodule

`default_nettype wire

// ==== dv/wiscFrontEndTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module wiscFrontEndTb import wiscPkg::*; ();

  // {regDst, jump, branch, memRead, memToReg, memWrite, aluSrc, regWrite,
  //  fiveBitImm, zeroExtend, halt}
  typedef logic [10:0] ctrlT;

  localparam int ImemWords   = 2 ** $bits(pcT);
  localparam int BitRegDst   = 10;
  localparam int BitFiveBit  = 2;
  localparam int BitZeroExt  = 1;
  localparam int DecodeLimit = 200;   // Cycles allowed for one wait
  localparam int QuietWindow = 30;    // Cycles watched after a halt

  logic   clk;
  logic   rstN;
  logic   start;
  logic   stall;
  logic   imemWe;
  pcT     imemAddr;
  instrT  imemData;
  logic   busy;
  logic   halt;
  logic   decValid;
  pcT     decAddr;
  opcodeT aluOp;
  logic   regDst;
  logic   jump;
  logic   branch;
  logic   memRead;
  logic   memToReg;
  logic   memWrite;
  logic   aluSrc;
  logic   regWrite;
  logic   fiveBitImm;
  logic   zeroExtend;
  regIdxT rsIdx;
  regIdxT rtIdx;
  regIdxT wrIdx;
  immT    imm;

  instrT prog [ImemWords];   // Program image and the expected decode order

  wiscFrontEnd i_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic ctrlT refCtrl(opcodeT op);
    case (op)
      5'h00:                                    return 11'b00000000001;   // HALT
      5'h04:                                    return 11'b01000000000;   // J
      5'h05:                                    return 11'b01000010000;   // JR
      5'h06:                                    return 11'b01000001000;   // JAL
      5'h07:                                    return 11'b01000011000;   // JALR
      5'h08, 5'h09, 5'h14, 5'h15, 5'h17:        return 11'b00000011100;
      5'h0a, 5'h0b:                             return 11'b00000011110;   // XORI, ANDNI
      5'h0c, 5'h0d, 5'h0e, 5'h0f:               return 11'b00100010000;   // Branches
      5'h10:                                    return 11'b00011110100;   // ST
      5'h11:                                    return 11'b00011011100;   // LD
      5'h12:                                    return 11'b00000011010;   // SLBI
      5'h13:                                    return 11'b00010111100;   // STU
      5'h16:                                    return 11'b00000001100;   // RORI
      5'h18:                                    return 11'b00000011000;   // LBI
      5'h19, 5'h1a, 5'h1b, 5'h1c, 5'h1d, 5'h1e, 5'h1f:
                                                return 11'b10000001000;   // Register forms
      default:                                  return '0;                // NOP, siic, RTI
    endcase
  endfunction

  // Field value taken as unsigned and shifted down by 2^n when the sign bit is set
  function automatic immT expectImm(instrT w, ctrlT c);
    int bits;
    int v;
    bits = c[BitFiveBit] ? 5 : 8;
    v = int'(w) & ((1 << bits) - 1);
    if (!c[BitZeroExt] && w[bits-1])
      v = v - (1 << bits);
    return immT'(v);
  endfunction

  function automatic instrT randomWord();
    opcodeT op;
    op = opcodeT'(1 + $urandom % 31);
    return {op, 11'($urandom)};
  endfunction

  task automatic abortRun();
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkCtrl(ctrlT got, ctrlT exp, string what);
    if (got !== exp)
    begin
      $display("FAILED at %0t ns: %s control %b, expected %b", $time, what, got, exp);
      abortRun();
    end
  endtask

  task automatic checkOp(opcodeT got, opcodeT exp, string what);
    if (got !== exp)
    begin
      $display("FAILED at %0t ns: %s aluOp %h, expected %h", $time, what, got, exp);
      abortRun();
    end
  endtask

  task automatic checkAddr(pcT got, pcT exp, string what);
    if (got !== exp)
    begin
      $display("FAILED at %0t ns: %s decAddr %0d, expected %0d", $time, what, got, exp);
      abortRun();
    end
  endtask

  task automatic checkIdx(regIdxT got, regIdxT exp, string what);
    if (got !== exp)
    begin
      $display("FAILED at %0t ns: %s index %0d, expected %0d", $time, what, got, exp);
      abortRun();
    end
  endtask

  task automatic checkImm(immT got, immT exp, string what);
    if (got !== exp)
    begin
      $display("FAILED at %0t ns: %s imm %h, expected %h", $time, what, got, exp);
      abortRun();
    end
  endtask

  task automatic checkLevel(logic got, logic exp, string what);
    if (got !== exp)
    begin
      $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      abortRun();
    end
  endtask

  task automatic checkBundle(instrT w, pcT a);
    ctrlT  exp;
    ctrlT  got;
    string what;
    exp  = refCtrl(w[15:11]);
    got  = {regDst, jump, branch, memRead, memToReg, memWrite, aluSrc, regWrite,
            fiveBitImm, zeroExtend, halt};
    what = $sformatf("word %h from %0d", w, a);
    checkAddr(decAddr, a, what);   // Catches lost or repeated words first
    checkCtrl(got, exp, what);
    checkOp(aluOp, w[15:11], what);
    checkIdx(rsIdx, w[10:8], {what, " rs"});
    checkIdx(rtIdx, w[7:5], {what, " rt"});
    checkIdx(wrIdx, exp[BitRegDst] ? w[4:2] : w[10:8], {what, " wr"});
    checkImm(imm, expectImm(w, exp), what);
  endtask

  // Unused addresses get a halt word tagged with its own address
  task automatic loadProgram(int n);
    for (int a = 0; a < ImemWords; a++)
    begin
      @(negedge clk);
      imemWe   = 1'b1;
      imemAddr = pcT'(a);
      imemData = (a < n) ? prog[a] : {10'b0, 6'(a)};
    end
    @(negedge clk);
    imemWe = 1'b0;
  endtask

  task automatic waitDecode(bit randStall);
    int cycles;
    cycles = 0;
    do
    begin
      if (randStall)
        stall = ($urandom % 3) == 0;
      @(negedge clk);
      cycles++;
      if (cycles > DecodeLimit)
      begin
        $display("Timed out after %0d cycles waiting for a decoded word", cycles);
        abortRun();
      end
    end
    while (!decValid);
  endtask

  task automatic waitIdle();
    int cycles;
    cycles = 0;
    while (busy)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > DecodeLimit)
      begin
        $display("Fetch unit still busy %0d cycles after the halt", cycles);
        abortRun();
      end
    end
  endtask

  // Start pulse and then nDecode words checked in order with a halt last
  task automatic runProgram(int nDecode, bit randStall);
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    checkLevel(busy, 1'b1, "busy after start");
    for (int i = 0; i < nDecode; i++)
    begin
      waitDecode(randStall);
      checkBundle(prog[i], pcT'(i));
    end
    stall = 1'b0;
    @(negedge clk);
    checkLevel(halt, 1'b1, "halt after the last word");
    checkLevel(decValid, 1'b0, "decValid after the halt word");
  endtask

  task automatic testReset();
    @(negedge clk);
    checkLevel(decValid, 1'b0, "decValid after reset");
    checkLevel(busy, 1'b0, "busy after reset");
    checkLevel(halt, 1'b0, "halt after reset");
  endtask

  task automatic testControlTable();
    for (int i = 0; i < 31; i++)
      prog[i] = {opcodeT'(i + 1), 11'($urandom)};
    prog[31] = {5'h00, 11'($urandom)};
    loadProgram(32);
    runProgram(32, 1'b0);
  endtask

  task automatic testImmediates();
    prog[0] = {5'h08, 3'd2, 3'd5, 5'b10110};         // ADDI with a negative 5-bit value
    prog[1] = {5'h09, 3'd7, 3'd1, 5'b01011};         // SUBI with a positive 5-bit value
    prog[2] = {5'h0b, 3'd3, 3'd4, 5'b11001};         // ANDNI zero-extends 5 bits
    prog[3] = {5'h18, 3'd1, 8'ha5};                  // LBI with a negative 8-bit value
    prog[4] = {5'h18, 3'd6, 8'h3c};                  // LBI with a positive 8-bit value
    prog[5] = {5'h12, 3'd5, 8'hf0};                  // SLBI zero-extends 8 bits
    prog[6] = {5'h1b, 3'd1, 3'd2, 3'd6, 2'b01};      // rd field selects r6
    prog[7] = {5'h11, 3'd4, 3'd3, 5'b00100};         // LD writes the rs register
    prog[8] = {5'h00, 11'h000};
    loadProgram(9);
    runProgram(9, 1'b0);
  endtask

  task automatic testHalt();
    for (int i = 0; i < 8; i++)
      prog[i] = randomWord();
    prog[3] = {5'h00, 11'($urandom)};
    loadProgram(8);
    runProgram(4, 1'b0);
    waitIdle();
    repeat (QuietWindow)
    begin
      @(negedge clk);
      checkLevel(decValid, 1'b0, "decValid after halt");
      checkLevel(halt, 1'b1, "halt level");
    end
    runProgram(4, 1'b1);   // Restart from address 0
  endtask

  task automatic testBackPressure();
    for (int i = 0; i < 20; i++)
      prog[i] = randomWord();
    prog[20] = {5'h00, 11'($urandom)};
    loadProgram(21);
    runProgram(21, 1'b1);
  endtask

  initial
  begin
    void'($urandom(32'h391116fc));
    rstN     = 1'b0;
    start    = 1'b0;
    stall    = 1'b0;
    imemWe   = 1'b0;
    imemAddr = '0;
    imemData = '0;
    repeat (3) @(negedge clk);
    rstN = 1'b1;
    testReset();
    testControlTable();
    testImmediates();
    testHalt();
    testBackPressure();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== wiscFrontEnd.f ====
+incdir+design
design/wiscPkg.sv
design/instrQueueIf.sv
design/fetchUnit.sv
design/instrQueue.sv
design/controlDecoder.sv
design/decodeStage.sv
design/wiscFrontEnd.sv
dv/wiscFrontEndTb.sv

// ==== Bender.yml ====
package:
  name: wiscFrontEnd

sources:
  - include_dirs:
      - design
    files:
      - design/wiscPkg.sv
      - design/instrQueueIf.sv
      - design/fetchUnit.sv
      - design/instrQueue.sv
      - design/controlDecoder.sv
      - design/decodeStage.sv
      - design/wiscFrontEnd.sv
  - target: simulation
    files:
      - dv/wiscFrontEndTb.sv
